// ==== include/bbc_glue_consts.svh ====
`ifndef BBC_GLUE_CONSTS_SVH
`define BBC_GLUE_CONSTS_SVH

// SHEILA is the I/O page at FE00-FEFF
`define SHEILA_PAGE 8'hFE

// FRED and JIM pages, which sit outside MOS ROM
`define FRED_PAGE 8'hFC
`define JIM_PAGE 8'hFD

// Register offsets within SHEILA
// ROM select and drive control decode four bytes each
`define ROMSEL_OFFS 8'h30
`define ACCCON_OFFS 8'h34
`define FDCON_OFFS 8'h24

// Page adds for scrolling wrap at 0x8000
// Mode 3 restarts at 0x4000, mode 6 at 0x6000
`define SCROLL_ADD_M3 4'd8
`define SCROLL_ADD_M6 4'd12
// Modes 0,1,2 restart at 0x3000, modes 4,5 at 0x5800
`define SCROLL_ADD_M012 4'd6
`define SCROLL_ADD_M45 4'd11

// Shadow RAM window on the Master
`define SHADOW_LO 16'h3000
`define SHADOW_HI 16'h7FFF

`endif

// ==== hdl/bbc_bus_pkg.sv ====
package bbc_bus_pkg;

	// One CPU bus cycle as seen by the glue
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic r_nw;
		logic sync;
	} cpu_bus_t;

	// One-hot selects, exactly one is set for any address
	// spare covers FRED and JIM, sheila the SHEILA bytes not owned here
	typedef struct packed {
		logic ram;
		logic rom;
		logic mos;
		logic romsel;
		logic acccon;
		logic fdcon;
		logic sheila;
		logic spare;
	} glue_sel_t;

	// Access control register at FE34 (Master)
	typedef struct packed {
		logic irr;
		logic tst;
		logic ifj;
		logic itu;
		logic y;
		logic x;
		logic e;
		logic d;
	} acccon_t;

	// Floppy drive control as driven to the FDC
	typedef struct packed {
		logic [3:0] drive;
		logic side;
		logic reset;
	} fdc_ctrl_t;

	// Addressable latch command from system VIA PB3..0
	typedef struct packed {
		logic data;
		logic [2:0] adr;
	} ic32_cmd_t;

endpackage

// ==== hdl/bbc_video_pkg.sv ====
package bbc_video_pkg;

	// Teletext view of the CRTC memory address
	typedef struct packed {
		logic mode;
		logic wrap;
		logic [1:0] page;
		logic [9:0] chr;
	} crtc_ttx_t;

	// High resolution view of the same address
	typedef struct packed {
		logic mode;
		logic wrap;
		logic [3:0] page;
		logic [7:0] col;
	} crtc_hires_t;

	// MA bit 13 picks which view is live
	typedef union packed {
		crtc_ttx_t ttx;
		crtc_hires_t hires;
	} crtc_ma_u;

	typedef struct packed {
		crtc_ma_u ma;
		logic [4:0] ra;
	} crtc_addr_t;

	// Screen offset code from IC32 bits 5..4
	typedef enum logic [1:0] {
		MODE3 = 2'd0,
		MODE6 = 2'd1,
		MODE012 = 2'd2,
		MODE45 = 2'd3
	} scr_offs_e;

	typedef logic [14:0] disp_addr_t;

endpackage

// ==== hdl/sheila_decode.sv ====
`timescale 1ns/10ps

`include "bbc_glue_consts.svh"

module sheila_decode
	import bbc_bus_pkg::*;
(
	input logic model_i,
	input cpu_bus_t bus_i,
	output glue_sel_t sel_o
);

	logic [7:0] page;
	logic [7:0] offs;
	logic io_page;
	logic sheila_page;
	logic romsel_hit;
	logic acccon_hit;
	logic fdcon_hit;

	assign page = bus_i.addr[15:8];
	assign offs = bus_i.addr[7:0];

	// FC00-FEFF is carved out of the MOS ROM
	assign io_page = (page == `FRED_PAGE) || (page == `JIM_PAGE) || (page == `SHEILA_PAGE);
	assign sheila_page = (page == `SHEILA_PAGE);

	// ROM select mirrors over FE30-FE33 on both models
	assign romsel_hit = sheila_page && (offs[7:2] == (`ROMSEL_OFFS >> 2));

	// Master only registers, dropped on model B
	assign acccon_hit = model_i && sheila_page && (offs == `ACCCON_OFFS);
	assign fdcon_hit = model_i && sheila_page && (offs[7:2] == (`FDCON_OFFS >> 2));

	always_comb begin
		sel_o = '0;
		sel_o.ram = (bus_i.addr[15] == 1'b0);
		sel_o.rom = (bus_i.addr[15:14] == 2'b10);
		sel_o.mos = (bus_i.addr[15:14] == 2'b11) && !io_page;
		sel_o.romsel = romsel_hit;
		sel_o.acccon = acccon_hit;
		sel_o.fdcon = fdcon_hit;
		// Remaining SHEILA bytes belong to peripherals outside the glue
		sel_o.sheila = sheila_page && !(romsel_hit || acccon_hit || fdcon_hit);
		// FRED and JIM
		sel_o.spare = io_page && !sheila_page;
	end

endmodule

// ==== hdl/system_latches.sv ====
`timescale 1ns/10ps

module system_latches
	import bbc_bus_pkg::*, bbc_video_pkg::*;
(
	input logic CLK48M_I,
	input logic reset_n,
	input logic model_i,
	input logic cpu_clken_i,
	input cpu_bus_t bus_i,
	input glue_sel_t sel_i,
	input ic32_cmd_t sys_pb_i,
	output logic [7:0] romsel_o,
	output acccon_t acccon_o,
	output fdc_ctrl_t fdc_ctrl_o,
	output logic [7:0] ic32_o,
	output scr_offs_e scr_offs_o,
	output logic vdu_op_o
);

	logic cpu_wr;

	// Writes only count on the CPU strobe
	assign cpu_wr = cpu_clken_i && !bus_i.r_nw;

	// ROM select latch, bit 7 only exists on the Master
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			romsel_o <= 8'h00;
		end else if (cpu_wr && sel_i.romsel) begin
			romsel_o <= {bus_i.wdata[7] & model_i, bus_i.wdata[6:0]};
		end
	end

	// Access control register
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			acccon_o <= '0;
		end else if (cpu_wr && sel_i.acccon) begin
			acccon_o <= acccon_t'(bus_i.wdata);
		end
	end

	// Drive control, select lines are active low on the data bus
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			fdc_ctrl_o.drive <= 4'b1111;
			fdc_ctrl_o.side <= 1'b0;
			fdc_ctrl_o.reset <= 1'b0;
		end else if (cpu_wr && sel_i.fdcon) begin
			fdc_ctrl_o.drive <= {2'b11, ~bus_i.wdata[1:0]};
			fdc_ctrl_o.reset <= bus_i.wdata[2];
			fdc_ctrl_o.side <= ~bus_i.wdata[4];
		end
	end

	// Last opcode fetch was in the VDU driver area C000-DFFF
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			vdu_op_o <= 1'b0;
		end else if (cpu_clken_i && bus_i.sync) begin
			vdu_op_o <= (bus_i.addr[15:13] == 3'b110);
		end
	end

	// IC32 follows the VIA port every clock
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			ic32_o <= 8'h00;
		end else begin
			ic32_o[sys_pb_i.adr] <= sys_pb_i.data;
		end
	end

	assign scr_offs_o = scr_offs_e'(ic32_o[5:4]);

endmodule

// ==== hdl/memory_mux.sv ====
`timescale 1ns/10ps

`include "bbc_glue_consts.svh"

module memory_mux
	import bbc_bus_pkg::*, bbc_video_pkg::*;
(
	input logic phi0_i,
	input logic model_i,
	input cpu_bus_t bus_i,
	input glue_sel_t sel_i,
	input crtc_addr_t crtc_i,
	input scr_offs_e scr_offs_i,
	input acccon_t acccon_i,
	input logic [7:0] romsel_i,
	input logic vdu_op_i,
	input logic [7:0] mem_di_i,
	input logic ext_irq_i,
	output logic [15:0] mem_adr_o,
	output logic mem_we_o,
	output logic [7:0] mem_do_o,
	output logic [7:0] cpu_di_o,
	output logic shadow_ram_o,
	output logic irq_n_o
);

	logic [3:0] page_add;
	logic [3:0] page;
	disp_addr_t disp_a;
	logic in_shadow;

	always_comb begin
		case (scr_offs_i)
			MODE3: page_add = `SCROLL_ADD_M3;
			MODE6: page_add = `SCROLL_ADD_M6;
			MODE012: page_add = `SCROLL_ADD_M012;
			default: page_add = `SCROLL_ADD_M45;
		endcase
	end

	// MA bit 12 flags a fetch past the top of screen memory
	assign page = crtc_i.ma.hires.wrap ? crtc_i.ma.hires.page + page_add
		: crtc_i.ma.hires.page;

	// Teletext lives in the top 1K of its bank, hires adds the row address
	assign disp_a = crtc_i.ma.ttx.mode ? {page[3], 4'b1111, crtc_i.ma.ttx.chr}
		: {page, crtc_i.ma.hires.col, crtc_i.ra[2:0]};

	// CPU owns memory in phi0 high, video otherwise
	assign mem_adr_o = phi0_i ? bus_i.addr : {1'b0, disp_a};
	assign mem_we_o = phi0_i && !bus_i.r_nw;
	assign mem_do_o = bus_i.wdata;

	always_comb begin
		if (sel_i.ram || sel_i.rom || sel_i.mos) begin
			cpu_di_o = mem_di_i;
		end else if (sel_i.romsel && model_i) begin
			cpu_di_o = romsel_i;
		end else if (sel_i.acccon) begin
			cpu_di_o = acccon_i;
		end else begin
			// Undecoded locations read as zero
			cpu_di_o = 8'h00;
		end
	end

	assign in_shadow = (bus_i.addr >= `SHADOW_LO) && (bus_i.addr <= `SHADOW_HI);

	// VDU driver code sees shadow data, but not on its own opcode fetch
	assign shadow_ram_o = in_shadow
		&& (acccon_i.x || (acccon_i.e && vdu_op_i && !bus_i.sync));

	assign irq_n_o = !(acccon_i.irr || ext_irq_i);

endmodule

// ==== hdl/bbc_glue.sv ====
`timescale 1ns/10ps

module bbc_glue
	import bbc_bus_pkg::*, bbc_video_pkg::*;
(
	input logic CLK48M_I,
	input logic reset_n,
	input logic model_i,
	input logic cpu_clken_i,
	input logic cpu_phi0_i,
	input cpu_bus_t cpu_bus_i,
	input crtc_addr_t crtc_i,
	input ic32_cmd_t sys_pb_i,
	input logic [7:0] mem_di_i,
	input logic ext_irq_i,
	output logic [15:0] mem_adr_o,
	output logic mem_we_o,
	output logic [7:0] mem_do_o,
	output logic [7:0] cpu_di_o,
	output logic [7:0] romsel_o,
	output logic shadow_ram_o,
	output logic shadow_vid_o,
	output logic acc_y_o,
	output fdc_ctrl_t fdc_ctrl_o,
	output logic [7:0] ic32_o,
	output logic irq_n_o
);

	glue_sel_t sel;
	acccon_t acccon;
	scr_offs_e scr_offs;
	logic vdu_op;

	sheila_decode sheila_decode_i (
		.model_i(model_i),
		.bus_i(cpu_bus_i),
		.sel_o(sel)
	);

	system_latches system_latches_i (
		.CLK48M_I(CLK48M_I),
		.reset_n(reset_n),
		.model_i(model_i),
		.cpu_clken_i(cpu_clken_i),
		.bus_i(cpu_bus_i),
		.sel_i(sel),
		.sys_pb_i(sys_pb_i),
		.romsel_o(romsel_o),
		.acccon_o(acccon),
		.fdc_ctrl_o(fdc_ctrl_o),
		.ic32_o(ic32_o),
		.scr_offs_o(scr_offs),
		.vdu_op_o(vdu_op)
	);

	memory_mux memory_mux_i (
		.phi0_i(cpu_phi0_i),
		.model_i(model_i),
		.bus_i(cpu_bus_i),
		.sel_i(sel),
		.crtc_i(crtc_i),
		.scr_offs_i(scr_offs),
		.acccon_i(acccon),
		.romsel_i(romsel_o),
		.vdu_op_i(vdu_op),
		.mem_di_i(mem_di_i),
		.ext_irq_i(ext_irq_i),
		.mem_adr_o(mem_adr_o),
		.mem_we_o(mem_we_o),
		.mem_do_o(mem_do_o),
		.cpu_di_o(cpu_di_o),
		.shadow_ram_o(shadow_ram_o),
		.irq_n_o(irq_n_o)
	);

	// Display from shadow RAM and the Master Y bit go to the memory controller
	assign shadow_vid_o = acccon.d;
	assign acc_y_o = acccon.y;

endmodule

// ==== verif/bbc_glue_sva.sv ====
`timescale 1ns/10ps

module bbc_glue_sva
	import bbc_bus_pkg::*;
(
	input logic clk_i,
	input logic reset_n_i,
	input logic phi0_i,
	input logic mem_we_i,
	input logic [7:0] romsel_i,
	input fdc_ctrl_t fdc_ctrl_i
);

	int fail_count = 0;

	// ROM select comes out of reset cleared
	romsel_reset_a: assert property (@(posedge clk_i) !reset_n_i |=> romsel_i == 8'h00)
		else begin
			fail_count++;
			$error("ROM select not cleared by reset");
		end

	// Video phase never writes memory
	video_no_write_a: assert property (@(posedge clk_i) disable iff (!reset_n_i)
		!phi0_i |-> !mem_we_i)
		else begin
			fail_count++;
			$error("memory write enabled while phi0 is low");
		end

	// Only drives 0 and 1 exist
	drive_top_a: assert property (@(posedge clk_i) disable iff (!reset_n_i)
		fdc_ctrl_i.drive[3:2] == 2'b11)
		else begin
			fail_count++;
			$error("drive select top bits are not 11");
		end

endmodule

bind bbc_glue bbc_glue_sva bbc_glue_sva_i (
	.clk_i(CLK48M_I),
	.reset_n_i(reset_n),
	.phi0_i(cpu_phi0_i),
	.mem_we_i(mem_we_o),
	.romsel_i(romsel_o),
	.fdc_ctrl_i(fdc_ctrl_o)
);

// ==== verif/glue_checker.sv ====
`timescale 1ns/10ps

module glue_checker
	import bbc_bus_pkg::*, bbc_video_pkg::*;
(
	input logic clk_i,
	input logic reset_n_i,
	input logic model_i,
	input logic clken_i,
	input logic phi0_i,
	input cpu_bus_t bus_i,
	input crtc_addr_t crtc_i,
	input ic32_cmd_t pb_i,
	input logic [7:0] mem_di_i,
	input logic ext_irq_i,
	input int test_id_i,
	input logic [15:0] mem_adr_i,
	input logic mem_we_i,
	input logic [7:0] mem_do_i,
	input logic [7:0] cpu_di_i,
	input logic [7:0] romsel_i,
	input logic shadow_ram_i,
	input logic shadow_vid_i,
	input logic acc_y_i,
	input fdc_ctrl_t fdc_ctrl_i,
	input logic [7:0] ic32_i,
	input logic irq_n_i,
	output int error_count_o
);

	int errors = 0;
	logic [7:0] m_romsel;
	logic [7:0] m_acccon;
	logic [3:0] m_drive;
	logic m_side;
	logic m_fdc_rst;
	logic [7:0] m_ic32;
	logic m_vdu_op;

	assign error_count_o = errors;

	function automatic string test_label(input int id);
		case (id)
			1: return "romsel";
			2: return "acccon";
			3: return "drive_ctrl";
			4: return "ic32_display";
			5: return "shadow";
			6: return "cpu_phase";
			default: return "idle";
		endcase
	endfunction

	// Scroll wrap adds a mode dependent page count
	function automatic logic [14:0] display_address(input logic [13:0] ma, input logic [4:0] ra,
			input logic [1:0] offs);
		logic [3:0] add;
		logic [3:0] page;
		case (offs)
			2'd0: add = 4'd8;
			2'd1: add = 4'd12;
			2'd2: add = 4'd6;
			default: add = 4'd11;
		endcase
		page = ma[12] ? ma[11:8] + add : ma[11:8];
		if (ma[13]) begin
			return {page[3], 4'b1111, ma[9:0]};
		end
		return {page, ma[7:0], ra[2:0]};
	endfunction

	function automatic logic [7:0] cpu_read_data(input logic [15:0] adr, input logic model,
			input logic [7:0] mem_di);
		if (adr[15:8] < 8'hFC || adr[15:8] == 8'hFF) begin
			return mem_di;
		end
		if (adr[15:2] == 14'h3F8C) begin
			return model ? m_romsel : 8'h00;
		end
		if (adr == 16'hFE34 && model) begin
			return m_acccon;
		end
		return 8'h00;
	endfunction

	function automatic logic shadow_flag(input logic [15:0] adr, input logic sync);
		logic in_range;
		in_range = (adr >= 16'h3000) && (adr <= 16'h7FFF);
		return in_range && (m_acccon[2] || (m_acccon[1] && m_vdu_op && !sync));
	endfunction

	task automatic compare_value(input string field, input logic [15:0] exp,
			input logic [15:0] act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", test_label(test_id_i), field,
				exp, act);
		end
	endtask

	// Register model, updated by the write rule
	always @(posedge clk_i) begin
		if (!reset_n_i) begin
			m_romsel <= 8'h00;
			m_acccon <= 8'h00;
			m_drive <= 4'b1111;
			m_side <= 1'b0;
			m_fdc_rst <= 1'b0;
			m_ic32 <= 8'h00;
			m_vdu_op <= 1'b0;
		end else begin
			if (clken_i && !bus_i.r_nw) begin
				if (bus_i.addr[15:2] == 14'h3F8C) begin
					m_romsel <= {bus_i.wdata[7] & model_i, bus_i.wdata[6:0]};
				end
				if (bus_i.addr == 16'hFE34 && model_i) begin
					m_acccon <= bus_i.wdata;
				end
				if (bus_i.addr[15:2] == 14'h3F89 && model_i) begin
					m_drive <= {2'b11, ~bus_i.wdata[1:0]};
					m_fdc_rst <= bus_i.wdata[2];
					m_side <= ~bus_i.wdata[4];
				end
			end
			if (clken_i && bus_i.sync) begin
				m_vdu_op <= (bus_i.addr >= 16'hC000) && (bus_i.addr <= 16'hDFFF);
			end
			m_ic32[pb_i.adr] <= pb_i.data;
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk_i) begin
		if (reset_n_i) begin
			compare_value("romsel_o", 16'(m_romsel), 16'(romsel_i));
			compare_value("shadow_vid_o", 16'(m_acccon[0]), 16'(shadow_vid_i));
			compare_value("acc_y_o", 16'(m_acccon[3]), 16'(acc_y_i));
			compare_value("fdc_ctrl_o", 16'({m_drive, m_side, m_fdc_rst}), 16'(fdc_ctrl_i));
			compare_value("ic32_o", 16'(m_ic32), 16'(ic32_i));
			compare_value("mem_adr_o", phi0_i ? bus_i.addr
				: {1'b0, display_address(crtc_i[18:5], crtc_i[4:0], m_ic32[5:4])}, mem_adr_i);
			compare_value("mem_we_o", 16'(phi0_i && !bus_i.r_nw), 16'(mem_we_i));
			compare_value("mem_do_o", 16'(bus_i.wdata), 16'(mem_do_i));
			compare_value("cpu_di_o", 16'(cpu_read_data(bus_i.addr, model_i, mem_di_i)),
				16'(cpu_di_i));
			compare_value("shadow_ram_o", 16'(shadow_flag(bus_i.addr, bus_i.sync)),
				16'(shadow_ram_i));
			compare_value("irq_n_o", 16'(!(m_acccon[7] || ext_irq_i)), 16'(irq_n_i));
		end
	end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_o,
	output logic reset_n_o
);

	// 10 ns period
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	// Reset held over the first four rising edges
	initial begin
		reset_n_o = 1'b0;
		repeat (4) @(posedge clk_o);
		reset_n_o <= 1'b1;
	end

endmodule

// ==== verif/tb_bbc_glue.sv ====
`timescale 1ns/10ps

module tb_bbc_glue
	import bbc_bus_pkg::*, bbc_video_pkg::*;
();

	// Cycles per test in order, then the run limit
	localparam int TEST_CYCLES = 42 + 18 + 26 + 49 + 32 + 25;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

	logic clk;
	logic reset_n;
	logic model;
	logic clken;
	logic phi0;
	cpu_bus_t bus;
	crtc_addr_t crtc;
	ic32_cmd_t pb;
	logic [7:0] mem_di;
	logic ext_irq;
	logic [15:0] mem_adr;
	logic mem_we;
	logic [7:0] mem_do;
	logic [7:0] cpu_di;
	logic [7:0] romsel;
	logic shadow_ram;
	logic shadow_vid;
	logic acc_y;
	fdc_ctrl_t fdc_ctrl;
	logic [7:0] ic32;
	logic irq_n;
	int test_id;
	int errors;
	int sva_fails;
	int cycles = 0;
	logic [31:0] lcg_state;

	tb_clock_gen clock_gen_i (
		.clk_o(clk),
		.reset_n_o(reset_n)
	);

	bbc_glue bbc_glue_i (
		.CLK48M_I(clk),
		.reset_n(reset_n),
		.model_i(model),
		.cpu_clken_i(clken),
		.cpu_phi0_i(phi0),
		.cpu_bus_i(bus),
		.crtc_i(crtc),
		.sys_pb_i(pb),
		.mem_di_i(mem_di),
		.ext_irq_i(ext_irq),
		.mem_adr_o(mem_adr),
		.mem_we_o(mem_we),
		.mem_do_o(mem_do),
		.cpu_di_o(cpu_di),
		.romsel_o(romsel),
		.shadow_ram_o(shadow_ram),
		.shadow_vid_o(shadow_vid),
		.acc_y_o(acc_y),
		.fdc_ctrl_o(fdc_ctrl),
		.ic32_o(ic32),
		.irq_n_o(irq_n)
	);

	glue_checker glue_checker_i (
		.clk_i(clk),
		.reset_n_i(reset_n),
		.model_i(model),
		.clken_i(clken),
		.phi0_i(phi0),
		.bus_i(bus),
		.crtc_i(crtc),
		.pb_i(pb),
		.mem_di_i(mem_di),
		.ext_irq_i(ext_irq),
		.test_id_i(test_id),
		.mem_adr_i(mem_adr),
		.mem_we_i(mem_we),
		.mem_do_i(mem_do),
		.cpu_di_i(cpu_di),
		.romsel_i(romsel),
		.shadow_ram_i(shadow_ram),
		.shadow_vid_i(shadow_vid),
		.acc_y_i(acc_y),
		.fdc_ctrl_i(fdc_ctrl),
		.ic32_i(ic32),
		.irq_n_i(irq_n),
		.error_count_o(errors)
	);

	// Failures seen by the bound assertions
	assign sva_fails = bbc_glue_i.bbc_glue_sva_i.fail_count;

	function automatic logic [15:0] lcg_step();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic logic [7:0] random_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	// One bus cycle, held until the next rising edge
	task automatic bus_cycle(input logic [15:0] adr, input logic [7:0] data, input logic r_nw,
			input logic sync, input logic strobe);
		@(posedge clk);
		bus <= '{addr: adr, wdata: data, r_nw: r_nw, sync: sync};
		clken <= strobe;
		mem_di <= random_byte();
	endtask

	task automatic write_reg(input logic [15:0] adr, input logic [7:0] data);
		bus_cycle(adr, data, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic read_reg(input logic [15:0] adr);
		bus_cycle(adr, 8'h00, 1'b1, 1'b0, 1'b1);
	endtask

	task automatic start_test(input int id, input logic m, input logic p);
		@(posedge clk);
		test_id <= id;
		model <= m;
		phi0 <= p;
		clken <= 1'b0;
		bus.r_nw <= 1'b1;
		bus.sync <= 1'b0;
	endtask

	task automatic drive_crtc();
		logic [15:0] w;
		logic [7:0] b;
		w = lcg_step();
		b = random_byte();
		@(posedge clk);
		crtc <= {w[13:0], b[4:0]};
	endtask

	task automatic romsel_writes();
		int i;
		start_test(1, 1'b1, 1'b1);
		for (i = 0; i < 8; i++) begin
			write_reg({14'h3F8C, i[1:0]}, random_byte());
			read_reg({14'h3F8C, i[1:0]});
		end
		// No strobe, no write
		for (i = 0; i < 4; i++) begin
			bus_cycle(16'hFE30, random_byte(), 1'b0, 1'b0, 1'b0);
			read_reg(16'hFE30);
		end
		start_test(1, 1'b0, 1'b1);
		for (i = 0; i < 8; i++) begin
			write_reg({14'h3F8C, i[1:0]}, random_byte());
			read_reg({14'h3F8C, i[1:0]});
		end
	endtask

	task automatic acccon_writes();
		int i;
		start_test(2, 1'b1, 1'b1);
		for (i = 0; i < 8; i++) begin
			write_reg(16'hFE34, random_byte());
			ext_irq <= random_byte() > 8'd127;
			read_reg(16'hFE34);
		end
		write_reg(16'hFE34, 8'h00);
		ext_irq <= 1'b0;
	endtask

	task automatic drive_ctrl_writes();
		int i;
		// Model B first, while the register still holds its reset value
		start_test(3, 1'b0, 1'b1);
		for (i = 0; i < 4; i++) begin
			write_reg({14'h3F89, i[1:0]}, random_byte());
			read_reg({14'h3F89, i[1:0]});
		end
		start_test(3, 1'b1, 1'b1);
		for (i = 0; i < 8; i++) begin
			write_reg({14'h3F89, i[1:0]}, random_byte());
			read_reg({14'h3F89, i[1:0]});
		end
	endtask

	task automatic display_addressing();
		int i;
		int offs;
		start_test(4, 1'b1, 1'b0);
		// CPU write left on the bus, video phase must keep it off memory
		bus.r_nw <= 1'b0;
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
			pb <= '{data: random_byte() > 8'd127, adr: i[2:0]};
		end
		// Screen offset sits in IC32 bits 5..4
		for (offs = 0; offs < 4; offs++) begin
			@(posedge clk);
			pb <= '{data: offs[0], adr: 3'd4};
			@(posedge clk);
			pb <= '{data: offs[1], adr: 3'd5};
			for (i = 0; i < 8; i++) begin
				drive_crtc();
			end
		end
	endtask

	task automatic shadow_flagging();
		int i;
		start_test(5, 1'b1, 1'b1);
		write_reg(16'hFE34, 8'h04);
		for (i = 0; i < 8; i++) begin
			read_reg(i[0] ? 16'h3000 + (lcg_step() & 16'h3FFF) : lcg_step());
		end
		read_reg(16'h2FFF);
		read_reg(16'h3000);
		read_reg(16'h7FFF);
		read_reg(16'h8000);
		// E only, shadow follows the last opcode fetch
		write_reg(16'hFE34, 8'h02);
		for (i = 0; i < 4; i++) begin
			bus_cycle(16'hC000 + (lcg_step() & 16'h1FFF), 8'h00, 1'b1, 1'b1, 1'b1);
			read_reg(16'h3000 + (lcg_step() & 16'h3FFF));
			bus_cycle(16'h8000, 8'h00, 1'b1, 1'b1, 1'b1);
			read_reg(16'h3000 + (lcg_step() & 16'h3FFF));
		end
		write_reg(16'hFE34, 8'h00);
	endtask

	task automatic cpu_phase_accesses();
		int i;
		start_test(6, 1'b1, 1'b1);
		for (i = 0; i < 16; i++) begin
			bus_cycle(lcg_step(), random_byte(), random_byte() > 8'd127, 1'b0, 1'b0);
		end
		read_reg(lcg_step() & 16'h7FFF);
		read_reg(16'h8000 | (lcg_step() & 16'h3FFF));
		read_reg(16'hC000 + (lcg_step() & 16'h1FFF));
		read_reg(16'hFF00 | {8'h00, random_byte()});
		read_reg(16'hFE40);
		read_reg(16'hFE00);
		read_reg(16'hFC00 | {8'h00, random_byte()});
		read_reg(16'hFD00 | {8'h00, random_byte()});
	endtask

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		lcg_state = 32'd39;
		test_id = 0;
		model = 1'b1;
		clken = 1'b0;
		phi0 = 1'b1;
		bus = '{addr: 16'h0000, wdata: 8'h00, r_nw: 1'b1, sync: 1'b0};
		crtc = '0;
		pb = '0;
		mem_di = 8'h00;
		ext_irq = 1'b0;
		wait (reset_n === 1'b1);
		romsel_writes();
		acccon_writes();
		drive_ctrl_writes();
		display_addressing();
		shadow_flagging();
		cpu_phase_accesses();
		start_test(0, 1'b1, 1'b1);
		repeat (2) @(posedge clk);
		$display("Checks finished with %0d compare errors and %0d assertion failures", errors,
			sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== bbc_glue.f ====
+incdir+include
hdl/bbc_bus_pkg.sv
hdl/bbc_video_pkg.sv
hdl/sheila_decode.sv
hdl/system_latches.sv
hdl/memory_mux.sv
hdl/bbc_glue.sv
verif/bbc_glue_sva.sv
verif/glue_checker.sv
verif/tb_clock_gen.sv
verif/tb_bbc_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f bbc_glue.f --top-module tb_bbc_glue

# The log decides pass or fail, so a stopped run is not fatal here
./obj_dir/Vtb_bbc_glue +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Verification passed$" sim.log; then
	exit 0
fi
exit 1
